// ==== rtl/des_round_cfg.svh ====
`ifndef DES_ROUND_CFG_SVH
`define DES_ROUND_CFG_SVH

////////////////////////////////////////////////////////////
// block and key widths
////////////////////////////////////////////////////////////

// one half of the 64-bit block
`define DES_HALF_W      32
// round subkey, same width as the expanded half
`define DES_KEY_W       48

////////////////////////////////////////////////////////////
// substitution stage
////////////////////////////////////////////////////////////

`define DES_SBOX_COUNT  8
`define DES_SBOX_IN_W   6
`define DES_SBOX_OUT_W  4

`endif

// ==== rtl/des_round_pkg.sv ====
package des_round_pkg;

`include "des_round_cfg.svh"

  ////////////////////////////////////////////////////////////
  // block data
  ////////////////////////////////////////////////////////////

  typedef logic [`DES_HALF_W-1:0] half_t;

  typedef logic [`DES_KEY_W-1:0] subkey_t;

  // left half in the upper 32 bits
  typedef struct packed {
    half_t l;
    half_t r;
  } round_data_t;

  ////////////////////////////////////////////////////////////
  // s-box words
  ////////////////////////////////////////////////////////////

  // outer bits pick the row, inner four bits the column
  typedef struct packed {
    logic                       row_hi;
    logic [`DES_SBOX_IN_W-3:0]  col;
    logic                       row_lo;
  } sbox_sel_t;

  // raw slice as cut from the mixed word, or its table select view
  typedef union packed {
    logic [`DES_SBOX_IN_W-1:0]  raw;
    sbox_sel_t                  sel;
  } sbox_in_u;

  typedef logic [`DES_SBOX_OUT_W-1:0] sbox_out_t;

endpackage

// ==== rtl/des_sbox.sv ====
`timescale 1ns/1ps

module des_sbox #(
  parameter int BOX_INDEX = 1
) (
  input  des_round_pkg::sbox_in_u  sbox_in,
  output des_round_pkg::sbox_out_t sbox_out
);
  import des_round_pkg::*;

  ////////////////////////////////////////////////////////////
  // standard tables
  ////////////////////////////////////////////////////////////

  // one 64-bit word per row, column 0 in the top nibble
  localparam sbox_out_t [1:8][0:3][0:15] SBOX_ALL = {
    // s1
    64'hE4D12FB83A6C5907,
    64'h0F74E2D1A6CB9538,
    64'h41E8D62BFC973A50,
    64'hFC8249175B3EA06D,
    // s2
    64'hF18E6B34972DC05A,
    64'h3D47F28EC01A69B5,
    64'h0E7BA4D158C6932F,
    64'hD8A13F42B67C05E9,
    // s3
    64'hA09E63F51DC7B428,
    64'hD709346A285ECBF1,
    64'hD6498F30B12C5AE7,
    64'h1AD069874FE3B52C,
    // s4
    64'h7DE3069A1285BC4F,
    64'hD8B56F03472C1AE9,
    64'hA690CB7DF13E5284,
    64'h3F06A1D8945BC72E,
    // s5
    64'h2C417AB6853FD0E9,
    64'hEB2C47D150FA3986,
    64'h421BAD78F9C5630E,
    64'hB8C71E2D6F09A453,
    // s6
    64'hC1AF92680D34E75B,
    64'hAF427C9561DE0B38,
    64'h9EF528C3704A1DB6,
    64'h432C95FABE17608D,
    // s7
    64'h4B2EF08D3C975A61,
    64'hD0B7491AE35C2F86,
    64'h14BDC37EAF680592,
    64'h6BD814A7950FE23C,
    // s8
    64'hD2846FB1A93E50C7,
    64'h1FD8A374C56B0E92,
    64'h7B419CE206ADF358,
    64'h21E74A8DFC90356B
  };

  // table of this instance only
  localparam sbox_out_t [0:3][0:15] TABLE = SBOX_ALL[BOX_INDEX];

  ////////////////////////////////////////////////////////////
  // lookup
  ////////////////////////////////////////////////////////////

  logic [1:0] row;

  // first and last input bits form the row number
  assign row = {sbox_in.sel.row_hi, sbox_in.sel.row_lo};

  assign sbox_out = TABLE[row][sbox_in.sel.col];

endmodule

// ==== rtl/des_feistel_f.sv ====
`timescale 1ns/1ps
`include "des_round_cfg.svh"

module des_feistel_f (
  input  des_round_pkg::half_t   r_half,
  input  des_round_pkg::subkey_t subkey,
  output des_round_pkg::half_t   f_out
);
  import des_round_pkg::*;

  ////////////////////////////////////////////////////////////
  // permutation orders
  ////////////////////////////////////////////////////////////

  // bit numbers as in the standard, bit 1 is the msb
  localparam logic [0:`DES_KEY_W-1][5:0] E_ORDER = {
    6'd32, 6'd1,  6'd2,  6'd3,  6'd4,  6'd5,
    6'd4,  6'd5,  6'd6,  6'd7,  6'd8,  6'd9,
    6'd8,  6'd9,  6'd10, 6'd11, 6'd12, 6'd13,
    6'd12, 6'd13, 6'd14, 6'd15, 6'd16, 6'd17,
    6'd16, 6'd17, 6'd18, 6'd19, 6'd20, 6'd21,
    6'd20, 6'd21, 6'd22, 6'd23, 6'd24, 6'd25,
    6'd24, 6'd25, 6'd26, 6'd27, 6'd28, 6'd29,
    6'd28, 6'd29, 6'd30, 6'd31, 6'd32, 6'd1
  };

  localparam logic [0:`DES_HALF_W-1][5:0] P_ORDER = {
    6'd16, 6'd7,  6'd20, 6'd21, 6'd29, 6'd12, 6'd28, 6'd17,
    6'd1,  6'd15, 6'd23, 6'd26, 6'd5,  6'd18, 6'd31, 6'd10,
    6'd2,  6'd8,  6'd24, 6'd14, 6'd32, 6'd27, 6'd3,  6'd9,
    6'd19, 6'd13, 6'd30, 6'd6,  6'd22, 6'd11, 6'd4,  6'd25
  };

  subkey_t expanded;
  subkey_t mixed;
  half_t   sbox_cat;

  ////////////////////////////////////////////////////////////
  // expansion and key mixing
  ////////////////////////////////////////////////////////////

  always_comb
  begin
    for (int i = 0; i < `DES_KEY_W; i++)
    begin
      expanded[`DES_KEY_W-1-i] = r_half[`DES_HALF_W - int'(E_ORDER[i])];
    end
  end

  assign mixed = expanded ^ subkey;

  ////////////////////////////////////////////////////////////
  // substitution
  ////////////////////////////////////////////////////////////

  // box 1 takes the top six bits and fills the top nibble
  for (genvar g = 0; g < `DES_SBOX_COUNT; g++)
  begin : g_sbox
    sbox_in_u slice;

    assign slice.raw = mixed[`DES_KEY_W-1-g*`DES_SBOX_IN_W -: `DES_SBOX_IN_W];

    des_sbox #(
      .BOX_INDEX (g + 1)
    ) u_sbox (
      .sbox_in  (slice),
      .sbox_out (sbox_cat[`DES_HALF_W-1-g*`DES_SBOX_OUT_W -: `DES_SBOX_OUT_W])
    );
  end

  // p permutation of the joined box outputs
  always_comb
  begin
    for (int i = 0; i < `DES_HALF_W; i++)
    begin
      f_out[`DES_HALF_W-1-i] = sbox_cat[`DES_HALF_W - int'(P_ORDER[i])];
    end
  end

endmodule

// ==== rtl/des_round.sv ====
`timescale 1ns/1ps

module des_round (
  input  logic                       Encryp_clk,
  input  logic                       Encryp_rst_n,
  input  logic                       in_valid,
  output logic                       in_ready,
  input  des_round_pkg::round_data_t in_data,
  input  des_round_pkg::subkey_t     in_subkey,
  output logic                       out_valid,
  input  logic                       out_ready,
  output des_round_pkg::round_data_t out_data
);
  import des_round_pkg::*;

  half_t       f_out;
  round_data_t next_data;
  logic        in_fire;

  ////////////////////////////////////////////////////////////
  // handshake
  ////////////////////////////////////////////////////////////

  // room when empty or when the held item leaves this cycle
  assign in_ready = !out_valid || out_ready;
  assign in_fire  = in_valid && in_ready;

  ////////////////////////////////////////////////////////////
  // feistel combine
  ////////////////////////////////////////////////////////////

  des_feistel_f u_feistel_f (
    .r_half (in_data.r),
    .subkey (in_subkey),
    .f_out  (f_out)
  );

  // halves swap, new right half carries the f result
  assign next_data.l = in_data.r;
  assign next_data.r = in_data.l ^ f_out;

  ////////////////////////////////////////////////////////////
  // output register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge Encryp_clk or negedge Encryp_rst_n)
  begin
    if (!Encryp_rst_n)
    begin
      out_valid <= 1'b0;
      out_data  <= '0;
    end
    else if (in_fire)
    begin
      out_valid <= 1'b1;
      out_data  <= next_data;
    end
    else if (out_ready)
    begin
      // drained with nothing behind it
      out_valid <= 1'b0;
    end
  end

endmodule

// ==== test/des_round_props.sv ====
`timescale 1ns/1ps

module des_round_props (
  input logic                       Encryp_clk,
  input logic                       Encryp_rst_n,
  input logic                       in_ready,
  input logic                       out_valid,
  input logic                       out_ready,
  input des_round_pkg::round_data_t out_data
);

  // failed assertions so far
  int   assert_fails = 0;
  logic stalled;

  assign stalled = out_valid && !out_ready;

  ////////////////////////////////////////////////////////////
  // output side
  ////////////////////////////////////////////////////////////

  hold_while_stalled: assert property (
    @(posedge Encryp_clk) disable iff (!Encryp_rst_n)
    stalled |=> (out_valid && $stable(out_data))
  )
  else
  begin
    $error("held output moved while the sink stalled");
    assert_fails++;
  end

  idle_in_reset: assert property (
    @(posedge Encryp_clk)
    !Encryp_rst_n |-> !out_valid
  )
  else
  begin
    $error("out_valid high during reset");
    assert_fails++;
  end

  // no room for a new item while the held one waits
  no_accept_when_stalled: assert property (
    @(posedge Encryp_clk) disable iff (!Encryp_rst_n)
    stalled |-> !in_ready
  )
  else
  begin
    $error("in_ready high while the output is stalled");
    assert_fails++;
  end

endmodule

bind des_round des_round_props u_props (
  .Encryp_clk   (Encryp_clk),
  .Encryp_rst_n (Encryp_rst_n),
  .in_ready     (in_ready),
  .out_valid    (out_valid),
  .out_ready    (out_ready),
  .out_data     (out_data)
);

// ==== test/des_round_tb.sv ====
`timescale 1ns/1ps

module des_round_tb;
  import des_round_pkg::*;

  ////////////////////////////////////////////////////////////
  // run limits
  ////////////////////////////////////////////////////////////

  localparam int CLK_HALF     = 2;
  localparam int RESET_CYCLES = 16;
  localparam int SAMPLE_DELAY = 1;
  localparam int WAIT_LIMIT   = 50;
  localparam int RANDOM_COUNT = 20;
  localparam int STREAM_COUNT = 10;
  localparam int STALL_CYCLES = 6;
  // six tests with their waits stay under about 400 cycles
  localparam int TEST_CYCLES    = 400;
  localparam int TIMEOUT_CYCLES = 5 * TEST_CYCLES;

  logic        Encryp_clk = 1'b0;
  logic        Encryp_rst_n;
  logic        in_valid;
  logic        in_ready;
  round_data_t in_data;
  subkey_t     in_subkey;
  logic        out_valid;
  logic        out_ready;
  round_data_t out_data;

  int          value_errors    = 0;
  int          protocol_errors = 0;
  int          cycle_count     = 0;
  logic [31:0] rng_state;
  // items taken from the output side, oldest first
  round_data_t got_q[$];

  des_round u_des_round (
    .Encryp_clk   (Encryp_clk),
    .Encryp_rst_n (Encryp_rst_n),
    .in_valid     (in_valid),
    .in_ready     (in_ready),
    .in_data      (in_data),
    .in_subkey    (in_subkey),
    .out_valid    (out_valid),
    .out_ready    (out_ready),
    .out_data     (out_data)
  );

  always #CLK_HALF Encryp_clk = ~Encryp_clk;

  always @(posedge Encryp_clk)
  begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES)
    begin
      $display("timeout: run still going after %0d cycles", TIMEOUT_CYCLES);
      $display("errors: %0d value, %0d protocol", value_errors, protocol_errors + 1);
      $display("TEST FAILED");
      $finish;
    end
  end

  // sample a little after the falling edge, when all inputs have settled
  always @(negedge Encryp_clk)
  begin
    #SAMPLE_DELAY;
    if (Encryp_rst_n && out_valid && out_ready)
    begin
      got_q.push_back(out_data);
    end
  end

  ////////////////////////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  function automatic subkey_t rand_subkey();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = xorshift32();
    lo = xorshift32();
    return {hi[15:0], lo};
  endfunction

  task automatic report_problem(input string msg);
    $display("ERROR at %0t: %s", $time, msg);
    protocol_errors++;
  endtask

  task automatic check_bit(input string name, input logic actual, input logic expected);
    if (actual !== expected)
    begin
      $display("FAILED at %0t: %s expected %b, got %b", $time, name, expected, actual);
      value_errors++;
    end
  endtask

  task automatic check_half(input string name, input half_t actual, input half_t expected);
    if (actual !== expected)
    begin
      $display("FAILED at %0t: %s expected %h, got %h", $time, name, expected, actual);
      value_errors++;
    end
  endtask

  task automatic check_data(input string name, input round_data_t actual,
                            input round_data_t expected);
    if (actual !== expected)
    begin
      $display("FAILED at %0t: %s expected %h, got %h", $time, name, expected, actual);
      value_errors++;
    end
  endtask

  // starts on a falling edge, returns on the falling edge after the transfer
  task automatic push_item(input round_data_t d, input subkey_t k, output int cycles);
    logic taken;
    taken     = 1'b0;
    cycles    = 0;
    in_valid  = 1'b1;
    in_data   = d;
    in_subkey = k;
    while (!taken && cycles < WAIT_LIMIT)
    begin
      #SAMPLE_DELAY;
      taken = in_ready;
      @(negedge Encryp_clk);
      cycles++;
    end
    in_valid = 1'b0;
    if (!taken)
    begin
      report_problem($sformatf("input not accepted within %0d cycles", WAIT_LIMIT));
    end
  endtask

  task automatic wait_outputs(input int count, output bit ok);
    int waited;
    waited = 0;
    while (got_q.size() < count && waited < WAIT_LIMIT)
    begin
      @(negedge Encryp_clk);
      waited++;
    end
    ok = (got_q.size() >= count);
    if (!ok)
    begin
      report_problem($sformatf("expected %0d outputs, only %0d left the DUT",
                               count, got_q.size()));
    end
  endtask

  ////////////////////////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////////////////////////

  task automatic idle_after_reset();
    #SAMPLE_DELAY;
    check_bit("out_valid", out_valid, 1'b0);
    check_bit("in_ready", in_ready, 1'b1);
    check_data("out_data", out_data, '0);
    @(negedge Encryp_clk);
  endtask

  // first round of the textbook DES example
  task automatic known_answer_round();
    round_data_t din;
    round_data_t want;
    int          cycles;
    bit          ok;
    din.l  = 32'hCC00_CCFF;
    din.r  = 32'hF0AA_F0AA;
    want.l = 32'hF0AA_F0AA;
    want.r = 32'hEF4A_6544;
    got_q.delete();
    out_ready = 1'b1;
    push_item(din, 48'h1B02_EFFC_7072, cycles);
    // one cycle after the transfer
    check_bit("out_valid", out_valid, 1'b1);
    check_data("out_data", out_data, want);
    wait_outputs(1, ok);
    if (ok)
    begin
      check_data("taken out_data", got_q[0], want);
    end
  endtask

  task automatic left_takes_right();
    round_data_t din [RANDOM_COUNT];
    int          cycles;
    bit          ok;
    got_q.delete();
    out_ready = 1'b1;
    for (int i = 0; i < RANDOM_COUNT; i++)
    begin
      din[i] = {xorshift32(), xorshift32()};
      push_item(din[i], rand_subkey(), cycles);
    end
    wait_outputs(RANDOM_COUNT, ok);
    if (ok)
    begin
      for (int i = 0; i < RANDOM_COUNT; i++)
      begin
        check_half($sformatf("out_data.l[%0d]", i), got_q[i].l, din[i].r);
      end
    end
  endtask

  // f depends only on r and the key, so r_out ^ l_in is constant
  task automatic key_linearity();
    half_t       l_in [RANDOM_COUNT];
    half_t       r_fixed;
    subkey_t     k_fixed;
    half_t       ref_f;
    round_data_t din;
    int          cycles;
    bit          ok;
    got_q.delete();
    out_ready = 1'b1;
    r_fixed   = xorshift32();
    k_fixed   = rand_subkey();
    for (int i = 0; i < RANDOM_COUNT; i++)
    begin
      l_in[i] = xorshift32();
      din.l   = l_in[i];
      din.r   = r_fixed;
      push_item(din, k_fixed, cycles);
    end
    wait_outputs(RANDOM_COUNT, ok);
    if (ok)
    begin
      ref_f = got_q[0].r ^ l_in[0];
      for (int i = 1; i < RANDOM_COUNT; i++)
      begin
        check_half($sformatf("out_data.r ^ in_data.l [%0d]", i), got_q[i].r ^ l_in[i], ref_f);
      end
    end
  endtask

  task automatic back_pressure_hold();
    round_data_t first;
    round_data_t second;
    round_data_t held;
    subkey_t     k;
    int          cycles;
    bit          ok;
    first  = {xorshift32(), xorshift32()};
    second = {xorshift32(), xorshift32()};
    k      = rand_subkey();
    got_q.delete();
    out_ready = 1'b0;
    push_item(first, k, cycles);
    check_bit("out_valid", out_valid, 1'b1);
    held = out_data;
    check_half("out_data.l", held.l, first.r);
    // second item is offered while the sink stalls
    in_valid  = 1'b1;
    in_data   = second;
    in_subkey = k;
    repeat (STALL_CYCLES)
    begin
      #SAMPLE_DELAY;
      check_bit("in_ready", in_ready, 1'b0);
      check_bit("out_valid", out_valid, 1'b1);
      check_data("out_data", out_data, held);
      @(negedge Encryp_clk);
    end
    out_ready = 1'b1;
    push_item(second, k, cycles);
    if (cycles != 1)
    begin
      report_problem("second item was not taken in the cycle the held item left");
    end
    check_half("out_data.l", out_data.l, second.r);
    wait_outputs(2, ok);
    if (ok)
    begin
      check_data("first taken item", got_q[0], held);
      check_half("second taken out_data.l", got_q[1].l, second.r);
    end
  endtask

  task automatic stream_in_order();
    round_data_t din [STREAM_COUNT];
    int          cycles;
    bit          ok;
    got_q.delete();
    out_ready = 1'b1;
    for (int i = 0; i < STREAM_COUNT; i++)
    begin
      din[i] = {xorshift32(), xorshift32()};
      push_item(din[i], rand_subkey(), cycles);
      if (cycles != 1)
      begin
        report_problem($sformatf("stream item %0d waited %0d cycles", i, cycles));
      end
    end
    wait_outputs(STREAM_COUNT, ok);
    if (ok)
    begin
      for (int i = 0; i < STREAM_COUNT; i++)
      begin
        check_half($sformatf("stream out_data.l[%0d]", i), got_q[i].l, din[i].r);
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////

  initial
  begin
    Encryp_rst_n = 1'b0;
    in_valid     = 1'b0;
    in_data      = '0;
    in_subkey    = '0;
    out_ready    = 1'b0;
    rng_state    = 32'd61743;
    repeat (RESET_CYCLES) @(negedge Encryp_clk);
    Encryp_rst_n = 1'b1;
    @(negedge Encryp_clk);

    idle_after_reset();
    known_answer_round();
    left_takes_right();
    key_linearity();
    back_pressure_hold();
    stream_in_order();

    repeat (2) @(negedge Encryp_clk);
    $display("errors: %0d value, %0d protocol, %0d assertion",
             value_errors, protocol_errors, u_des_round.u_props.assert_fails);
    if (value_errors + protocol_errors + u_des_round.u_props.assert_fails == 0)
    begin
      $display("TEST OK");
    end
    else
    begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== des_round.f ====
+incdir+rtl
rtl/des_round_pkg.sv
rtl/des_sbox.sv
rtl/des_feistel_f.sv
rtl/des_round.sv
test/des_round_props.sv
test/des_round_tb.sv

// ==== Makefile ====
# Verilator build and run for the DES round

VERILATOR ?= verilator
TOP       ?= des_round_tb
FILELIST  ?= des_round.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -j 0
SIMFLAGS  ?= +verilator+error+limit+1000
LOG       ?= sim.log

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
HEADERS := $(wildcard rtl/*.svh)

.PHONY: all run clean

all: $(SIM_BIN)

# rebuilt only when a source, header or the file list changes
$(SIM_BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILELIST)

run: $(SIM_BIN)
	@./$(SIM_BIN) $(SIMFLAGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "TEST FAILED" $(LOG); then \
	  echo "simulation failed, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
